// File: Bender.yml
package:
  name: l2_mem

sources:
  - logic/l2_bus_pkg.sv
  - logic/l2_serdes.sv
  - logic/sys_mem.sv
  - logic/l2_mem_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_l2_mem_top.sv

// File: build.f
logic/l2_bus_pkg.sv
logic/l2_serdes.sv
logic/sys_mem.sv
logic/l2_mem_top.sv
tb/tb_clk_gen.sv
tb/tb_l2_mem_top.sv

// File: logic/l2_bus_pkg.sv
package l2_bus_pkg;

    // Line and beat geometry
    localparam int LINE_W    = 256;
    localparam int BUS_W     = 64;
    localparam int LINE_B    = LINE_W / 8;
    localparam int BUS_B     = BUS_W / 8;
    localparam int BURST_LEN = LINE_W / BUS_W;    // Beats per line
    localparam int ADDR_W    = 32;

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [LINE_B-1:0] line_strb_t;
    typedef logic [BUS_W-1:0]  beat_t;
    typedef logic [BUS_B-1:0]  beat_strb_t;

    typedef logic [7:0] len_t;     // Beats minus one
    typedef logic [2:0] size_t;    // 0=1B 1=2B 2=4B 3=8B 4=16B 5=32B

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    // Largest size code that still fits in one line
    localparam size_t SIZE_LINE = 3'd5;

endpackage

// File: logic/l2_mem_top.sv
`timescale 1ns/1ns

module l2_mem_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_l2_ar_valid,
    output logic                           o_l2_ar_ready,
    input  logic [l2_bus_pkg::ADDR_W-1:0]  i_l2_ar_addr,
    input  l2_bus_pkg::size_t              i_l2_ar_size,
    input  logic                           i_l2_aw_valid,
    output logic                           o_l2_aw_ready,
    input  logic [l2_bus_pkg::ADDR_W-1:0]  i_l2_aw_addr,
    input  l2_bus_pkg::size_t              i_l2_aw_size,
    input  l2_bus_pkg::line_t              i_l2_w_data,
    input  l2_bus_pkg::line_strb_t         i_l2_w_strb,
    output logic                           o_l2_w_ready,
    output logic                           o_l2_r_valid,
    input  logic                           i_l2_r_ready,
    output l2_bus_pkg::line_t              o_l2_r_data,
    output l2_bus_pkg::resp_t              o_l2_r_resp,
    output logic                           o_l2_r_last,
    output logic                           o_l2_b_valid,
    input  logic                           i_l2_b_ready,
    output l2_bus_pkg::resp_t              o_l2_b_resp
);

    // System bus between the serdes and the memory
    logic                          ar_valid, ar_ready, aw_valid, aw_ready;
    logic [l2_bus_pkg::ADDR_W-1:0] ar_addr, aw_addr;
    l2_bus_pkg::len_t              ar_len, aw_len;
    logic                          r_valid, r_ready, r_last;
    l2_bus_pkg::beat_t             r_data, w_data;
    l2_bus_pkg::resp_t             r_resp, b_resp;
    logic                          w_valid, w_ready, w_last;
    l2_bus_pkg::beat_strb_t        w_strb;
    logic                          b_valid, b_ready;

    l2_serdes u_serdes (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_l2_ar_valid (i_l2_ar_valid),
        .o_l2_ar_ready (o_l2_ar_ready),
        .i_l2_ar_addr  (i_l2_ar_addr),
        .i_l2_ar_size  (i_l2_ar_size),
        .i_l2_aw_valid (i_l2_aw_valid),
        .o_l2_aw_ready (o_l2_aw_ready),
        .i_l2_aw_addr  (i_l2_aw_addr),
        .i_l2_aw_size  (i_l2_aw_size),
        .i_l2_w_data   (i_l2_w_data),
        .i_l2_w_strb   (i_l2_w_strb),
        .o_l2_w_ready  (o_l2_w_ready),
        .o_l2_r_valid  (o_l2_r_valid),
        .i_l2_r_ready  (i_l2_r_ready),
        .o_l2_r_data   (o_l2_r_data),
        .o_l2_r_resp   (o_l2_r_resp),
        .o_l2_r_last   (o_l2_r_last),
        .o_l2_b_valid  (o_l2_b_valid),
        .i_l2_b_ready  (i_l2_b_ready),
        .o_l2_b_resp   (o_l2_b_resp),
        .o_ar_valid    (ar_valid),
        .i_ar_ready    (ar_ready),
        .o_ar_addr     (ar_addr),
        .o_ar_len      (ar_len),
        .o_aw_valid    (aw_valid),
        .i_aw_ready    (aw_ready),
        .o_aw_addr     (aw_addr),
        .o_aw_len      (aw_len),
        .i_r_valid     (r_valid),
        .o_r_ready     (r_ready),
        .i_r_data      (r_data),
        .i_r_resp      (r_resp),
        .i_r_last      (r_last),
        .o_w_valid     (w_valid),
        .i_w_ready     (w_ready),
        .o_w_data      (w_data),
        .o_w_strb      (w_strb),
        .o_w_last      (w_last),
        .i_b_valid     (b_valid),
        .o_b_ready     (b_ready),
        .i_b_resp      (b_resp)
    );

    sys_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .i_ar_addr  (ar_addr),
        .i_ar_len   (ar_len),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_aw_addr  (aw_addr),
        .i_aw_len   (aw_len),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready),
        .o_r_data   (r_data),
        .o_r_resp   (r_resp),
        .o_r_last   (r_last),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .i_w_data   (w_data),
        .i_w_strb   (w_strb),
        .i_w_last   (w_last),
        .o_b_valid  (b_valid),
        .i_b_ready  (b_ready),
        .o_b_resp   (b_resp)
    );

endmodule

// File: logic/l2_serdes.sv
`timescale 1ns/1ns

module l2_serdes (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    // L2 read request
    input  logic                           i_l2_ar_valid,
    output logic                           o_l2_ar_ready,
    input  logic [l2_bus_pkg::ADDR_W-1:0]  i_l2_ar_addr,
    input  l2_bus_pkg::size_t              i_l2_ar_size,
    // L2 write request, line taken with the address
    input  logic                           i_l2_aw_valid,
    output logic                           o_l2_aw_ready,
    input  logic [l2_bus_pkg::ADDR_W-1:0]  i_l2_aw_addr,
    input  l2_bus_pkg::size_t              i_l2_aw_size,
    input  l2_bus_pkg::line_t              i_l2_w_data,
    input  l2_bus_pkg::line_strb_t         i_l2_w_strb,
    output logic                           o_l2_w_ready,
    // L2 completions
    output logic                           o_l2_r_valid,
    input  logic                           i_l2_r_ready,
    output l2_bus_pkg::line_t              o_l2_r_data,
    output l2_bus_pkg::resp_t              o_l2_r_resp,
    output logic                           o_l2_r_last,
    output logic                           o_l2_b_valid,
    input  logic                           i_l2_b_ready,
    output l2_bus_pkg::resp_t              o_l2_b_resp,
    // Bus master side
    output logic                           o_ar_valid,
    input  logic                           i_ar_ready,
    output logic [l2_bus_pkg::ADDR_W-1:0]  o_ar_addr,
    output l2_bus_pkg::len_t               o_ar_len,
    output logic                           o_aw_valid,
    input  logic                           i_aw_ready,
    output logic [l2_bus_pkg::ADDR_W-1:0]  o_aw_addr,
    output l2_bus_pkg::len_t               o_aw_len,
    input  logic                           i_r_valid,
    output logic                           o_r_ready,
    input  l2_bus_pkg::beat_t              i_r_data,
    input  l2_bus_pkg::resp_t              i_r_resp,
    input  logic                           i_r_last,
    output logic                           o_w_valid,
    input  logic                           i_w_ready,
    output l2_bus_pkg::beat_t              o_w_data,
    output l2_bus_pkg::beat_strb_t         o_w_strb,
    output logic                           o_w_last,
    input  logic                           i_b_valid,
    output logic                           o_b_ready,
    input  l2_bus_pkg::resp_t              i_b_resp
);

    localparam int LINE_W = l2_bus_pkg::LINE_W;
    localparam int BUS_W  = l2_bus_pkg::BUS_W;
    localparam int LINE_B = l2_bus_pkg::LINE_B;
    localparam int BUS_B  = l2_bus_pkg::BUS_B;
    localparam int NBEAT  = l2_bus_pkg::BURST_LEN;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} state_t;

    state_t                 state;
    l2_bus_pkg::len_t       rem;        // Beats left after the current one
    logic [NBEAT-1:0]       rmux;       // One-hot lane for the next read beat
    l2_bus_pkg::line_t      line_q;
    l2_bus_pkg::line_strb_t strb_q;
    l2_bus_pkg::line_t      line_merged;
    logic                   b_wait;
    logic                   r_err;      // Sticky error over the read burst
    logic                   ar_fire, aw_fire, r_fire, w_fire, last_beat;

    function automatic l2_bus_pkg::len_t size2len(input l2_bus_pkg::size_t size);
        l2_bus_pkg::len_t len;
        case (size)
            3'd4:                  len = 8'd1;
            l2_bus_pkg::SIZE_LINE: len = 8'(NBEAT - 1);
            default:               len = 8'd0;    // Single beat of the same size
        endcase
        return len;
    endfunction

    // Requests go straight to the bus, a read wins over a write
    assign o_ar_valid    = i_l2_ar_valid;
    assign o_ar_addr     = i_l2_ar_addr;
    assign o_ar_len      = size2len(i_l2_ar_size);
    assign o_aw_valid    = i_l2_aw_valid & ~i_l2_ar_valid;
    assign o_aw_addr     = i_l2_aw_addr;
    assign o_aw_len      = size2len(i_l2_aw_size);
    assign o_l2_ar_ready = i_ar_ready;
    assign o_l2_aw_ready = i_aw_ready & ~i_l2_ar_valid;

    assign ar_fire   = (state == ST_IDLE) & i_l2_ar_valid & i_ar_ready;
    assign aw_fire   = (state == ST_IDLE) & i_l2_aw_valid & o_l2_aw_ready;
    assign r_fire    = (state == ST_READ) & i_r_valid & i_l2_r_ready;
    assign w_fire    = o_w_valid & i_w_ready;
    assign last_beat = (rem == '0);

    // Current beat dropped into its lane
    always_comb begin
        line_merged = line_q;
        for (int i = 0; i < NBEAT; i++) begin
            if (rmux[i]) begin
                line_merged[i*BUS_W +: BUS_W] = i_r_data;
            end
        end
    end

    assign o_r_ready    = i_l2_r_ready;
    assign o_l2_r_valid = r_fire & last_beat;
    assign o_l2_r_last  = o_l2_r_valid;
    assign o_l2_r_data  = line_merged;
    assign o_l2_r_resp  = (r_err || i_r_resp != l2_bus_pkg::RESP_OKAY) ?
                          l2_bus_pkg::RESP_SLVERR : l2_bus_pkg::RESP_OKAY;

    assign o_w_valid    = (state == ST_WRITE);
    assign o_w_last     = o_w_valid & last_beat;
    assign o_w_data     = line_q[BUS_W-1:0];
    assign o_w_strb     = strb_q[BUS_B-1:0];
    assign o_l2_w_ready = w_fire & last_beat;

    assign o_b_ready    = i_l2_b_ready;
    assign o_l2_b_valid = i_b_valid & b_wait;    // Only answers our own write
    assign o_l2_b_resp  = i_b_resp;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state  <= ST_IDLE;
            rem    <= '0;
            rmux   <= '0;
            r_err  <= 1'b0;
            b_wait <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_fire) begin
                        state <= ST_READ;
                        rem   <= o_ar_len;
                        rmux  <= NBEAT'(1);
                        r_err <= 1'b0;
                    end else if (aw_fire) begin
                        state <= ST_WRITE;
                        rem   <= o_aw_len;
                    end
                end
                ST_READ: begin
                    if (r_fire) begin
                        rmux  <= {rmux[NBEAT-2:0], 1'b0};
                        r_err <= r_err | (i_r_resp != l2_bus_pkg::RESP_OKAY);
                        if (last_beat) begin
                            state <= ST_IDLE;
                        end else begin
                            rem <= rem - 8'd1;
                        end
                    end
                end
                ST_WRITE: begin
                    if (w_fire) begin
                        if (last_beat) begin
                            state <= ST_IDLE;
                        end else begin
                            rem <= rem - 8'd1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (o_l2_w_ready) begin
                b_wait <= 1'b1;
            end else if (i_b_valid && i_l2_b_ready) begin
                b_wait <= 1'b0;
            end
        end
    end

    // Line and strobes, shifted down one beat per accepted write beat
    always_ff @(posedge i_clk) begin
        if (r_fire) begin
            line_q <= line_merged;
        end else if (aw_fire) begin
            line_q <= i_l2_w_data;
            strb_q <= i_l2_w_strb;
        end else if (w_fire) begin
            line_q <= {{BUS_W{1'b0}}, line_q[LINE_W-1:BUS_W]};
            strb_q <= {{BUS_B{1'b0}}, strb_q[LINE_B-1:BUS_B]};
        end
    end

    a_size_ok: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_l2_ar_valid |-> i_l2_ar_size <= l2_bus_pkg::SIZE_LINE) and
        (i_l2_aw_valid |-> i_l2_aw_size <= l2_bus_pkg::SIZE_LINE));

    a_r_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_l2_r_valid |=> !o_l2_r_valid);

    // Slave burst end agrees with our own beat count
    a_r_last_match: assert property (@(posedge i_clk) disable iff (!i_nrst)
        r_fire |-> (i_r_last == last_beat));

endmodule

// File: logic/sys_mem.sv
`timescale 1ns/1ns

module sys_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_ar_valid,
    output logic                           o_ar_ready,
    input  logic [l2_bus_pkg::ADDR_W-1:0]  i_ar_addr,
    input  l2_bus_pkg::len_t               i_ar_len,
    input  logic                           i_aw_valid,
    output logic                           o_aw_ready,
    input  logic [l2_bus_pkg::ADDR_W-1:0]  i_aw_addr,
    input  l2_bus_pkg::len_t               i_aw_len,
    output logic                           o_r_valid,
    input  logic                           i_r_ready,
    output l2_bus_pkg::beat_t              o_r_data,
    output l2_bus_pkg::resp_t              o_r_resp,
    output logic                           o_r_last,
    input  logic                           i_w_valid,
    output logic                           o_w_ready,
    input  l2_bus_pkg::beat_t              i_w_data,
    input  l2_bus_pkg::beat_strb_t         i_w_strb,
    input  logic                           i_w_last,
    output logic                           o_b_valid,
    input  logic                           i_b_ready,
    output l2_bus_pkg::resp_t              o_b_resp
);

    localparam int OFS_W = $clog2(l2_bus_pkg::BUS_B);    // Byte offset within a word
    localparam int PTR_W = l2_bus_pkg::ADDR_W - OFS_W;
    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_RESP} state_t;

    l2_bus_pkg::beat_t mem [MEM_WORDS];

    state_t            state;
    logic [PTR_W-1:0]  ptr;      // Word address of the current beat
    logic [PTR_W-1:0]  last_ptr; // Word address of the final read beat
    logic [IDX_W-1:0]  idx;
    l2_bus_pkg::len_t  cnt;      // Read beats left
    logic              b_err;
    logic              in_range;
    logic              ar_fire, aw_fire, r_fire, w_fire;

    assign in_range = (ptr < PTR_W'(MEM_WORDS));
    assign idx      = ptr[IDX_W-1:0];

    assign o_ar_ready = (state == ST_IDLE);
    assign o_aw_ready = (state == ST_IDLE) & ~i_ar_valid;    // Reads first
    assign ar_fire    = i_ar_valid & o_ar_ready;
    assign aw_fire    = i_aw_valid & o_aw_ready;

    assign o_r_valid = (state == ST_READ);
    assign o_r_data  = in_range ? mem[idx] : '0;
    assign o_r_resp  = in_range ? l2_bus_pkg::RESP_OKAY : l2_bus_pkg::RESP_SLVERR;
    assign o_r_last  = o_r_valid & (cnt == '0);
    assign r_fire    = o_r_valid & i_r_ready;

    assign o_w_ready = (state == ST_WRITE);
    assign w_fire    = i_w_valid & o_w_ready;

    assign o_b_valid = (state == ST_RESP);
    assign o_b_resp  = b_err ? l2_bus_pkg::RESP_SLVERR : l2_bus_pkg::RESP_OKAY;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
            ptr   <= '0;
            cnt   <= '0;
            b_err <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_fire) begin
                        state <= ST_READ;
                        ptr   <= i_ar_addr[l2_bus_pkg::ADDR_W-1:OFS_W];
                        cnt   <= i_ar_len;
                    end else if (aw_fire) begin
                        state <= ST_WRITE;
                        ptr   <= i_aw_addr[l2_bus_pkg::ADDR_W-1:OFS_W];
                        cnt   <= i_aw_len;
                        b_err <= 1'b0;
                    end
                end
                ST_READ: begin
                    if (r_fire) begin
                        ptr <= ptr + 1'b1;
                        cnt <= cnt - 8'd1;
                        if (o_r_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_WRITE: begin
                    if (w_fire) begin
                        ptr   <= ptr + 1'b1;
                        cnt   <= cnt - 8'd1;
                        b_err <= b_err | ~in_range;    // Dropped beat
                        if (i_w_last) begin
                            state <= ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    if (i_b_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // End of the read burst as seen from the start address
    always_ff @(posedge i_clk) begin
        if (ar_fire) begin
            last_ptr <= i_ar_addr[l2_bus_pkg::ADDR_W-1:OFS_W] + PTR_W'(i_ar_len);
        end
    end

    // Byte lanes under strobe
    always_ff @(posedge i_clk) begin
        if (w_fire && in_range) begin
            for (int b = 0; b < l2_bus_pkg::BUS_B; b++) begin
                if (i_w_strb[b]) begin
                    mem[idx][b*8 +: 8] <= i_w_data[b*8 +: 8];
                end
            end
        end
    end

    // Last flag only on the word that closes the requested length
    a_r_last_final: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_r_valid |-> (o_r_last == (ptr == last_ptr)));

    a_w_in_burst: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_w_valid |-> (state == ST_WRITE) && !(i_w_last && cnt != '0));

endmodule

// File: tb/l2_mem_golden.txt
# name op bp addr size line_data line_strb expected_line resp
# op R or W, bp 1 randomizes the completion readies, addr lines strobes resp in hex
wr_line W 0 00000100 5 0f1e2d3c4b5a69788796a5b4c3d2e1f00123456789abcdeffedcba9876543210 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 0
rd_line R 0 00000100 5 0000000000000000000000000000000000000000000000000000000000000000 00000000 0f1e2d3c4b5a69788796a5b4c3d2e1f00123456789abcdeffedcba9876543210 0
rd_word2 R 0 00000110 2 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000000000000000000008796a5b4c3d2e1f0 0
wr_half W 0 00000200 4 a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a11112222333344445555666677778888 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 0
rd_half R 0 00000200 4 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000011112222333344445555666677778888 0
wr_base W 0 00000300 3 0000000000000000000000000000000000000000000000001122334455667788 000000ff 0000000000000000000000000000000000000000000000000000000000000000 0
wr_byte W 0 00000300 0 00000000000000000000000000000000000000000000000000000000ab000000 00000008 0000000000000000000000000000000000000000000000000000000000000000 0
rd_merge R 0 00000300 3 0000000000000000000000000000000000000000000000000000000000000000 00000000 00000000000000000000000000000000000000000000000011223344ab667788 0
wr_oob W 0 00004000 5 0f1e2d3c4b5a69788796a5b4c3d2e1f00123456789abcdeffedcba9876543210 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 2
rd_oob R 0 00004000 5 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000000000000000000000000000000000000 2
wr_edge W 0 00001ff0 5 cafef00dcafef00d0badc0de0badc0de13579bdf2468ace00fedcba987654321 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 2
rd_edge R 0 00001ff0 5 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000013579bdf2468ace00fedcba987654321 2
bp_wr_line W 1 00000500 5 cafef00dcafef00d0badc0de0badc0de13579bdf2468ace00fedcba987654321 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 0
bp_rd_line R 1 00000500 5 0000000000000000000000000000000000000000000000000000000000000000 00000000 cafef00dcafef00d0badc0de0badc0de13579bdf2468ace00fedcba987654321 0
bp_wr_half W 1 00000600 4 0f1e2d3c4b5a69788796a5b4c3d2e1f00123456789abcdeffedcba9876543210 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 0
bp_rd_half R 1 00000600 4 0000000000000000000000000000000000000000000000000000000000000000 00000000 000000000000000000000000000000000123456789abcdeffedcba9876543210 0
bp_rd_old R 1 00000100 5 0000000000000000000000000000000000000000000000000000000000000000 00000000 0f1e2d3c4b5a69788796a5b4c3d2e1f00123456789abcdeffedcba9876543210 0
bp_wr_oob W 1 00008000 1 0f1e2d3c4b5a69788796a5b4c3d2e1f00123456789abcdeffedcba9876543210 ffffffff 0000000000000000000000000000000000000000000000000000000000000000 2
bp_rd_oob R 1 00008000 2 0000000000000000000000000000000000000000000000000000000000000000 00000000 0000000000000000000000000000000000000000000000000000000000000000 2
bp_rd_merge R 1 00000300 3 0000000000000000000000000000000000000000000000000000000000000000 00000000 00000000000000000000000000000000000000000000000011223344ab667788 0

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Reset drops at time zero, released just after an edge
    initial begin
        o_nrst = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_nrst = 1'b1;
    end

endmodule

// File: tb/tb_l2_mem_top.sv
`timescale 1ns/1ns

module tb_l2_mem_top;

    localparam int    CLK_PERIOD  = 8;
    localparam int    RST_CYCLES  = 3;
    localparam int    TEST_CYCLES = 200;    // Watchdog budget per test
    localparam string GOLDEN      = "tb/l2_mem_golden.txt";

    logic                          clk, nrst;
    logic                          ar_valid, ar_ready, aw_valid, aw_ready;
    logic [l2_bus_pkg::ADDR_W-1:0] ar_addr, aw_addr;
    l2_bus_pkg::size_t             ar_size, aw_size;
    l2_bus_pkg::line_t             w_data, r_data;
    l2_bus_pkg::line_strb_t        w_strb;
    logic                          w_ready, r_valid, r_ready, r_last, b_valid, b_ready;
    l2_bus_pkg::resp_t             r_resp, b_resp;

    // Test table, one entry per golden line
    string                  t_name[$];
    string                  t_op[$];
    int                     t_bp[$];
    logic [31:0]            t_addr[$];
    int                     t_size[$];
    l2_bus_pkg::line_t      t_data[$];
    l2_bus_pkg::line_strb_t t_strb[$];
    l2_bus_pkg::line_t      t_exp[$];
    l2_bus_pkg::resp_t      t_resp[$];

    int          n_tests = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          test_errors;
    int          r_pulses, w_pulses;
    bit          bp_mode = 1'b0;
    logic [31:0] rng = 32'd49411;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    l2_mem_top #(.MEM_WORDS(1024)) dut (
        .i_clk (clk), .i_nrst (nrst),
        .i_l2_ar_valid (ar_valid), .o_l2_ar_ready (ar_ready),
        .i_l2_ar_addr (ar_addr), .i_l2_ar_size (ar_size),
        .i_l2_aw_valid (aw_valid), .o_l2_aw_ready (aw_ready),
        .i_l2_aw_addr (aw_addr), .i_l2_aw_size (aw_size),
        .i_l2_w_data (w_data), .i_l2_w_strb (w_strb), .o_l2_w_ready (w_ready),
        .o_l2_r_valid (r_valid), .i_l2_r_ready (r_ready), .o_l2_r_data (r_data),
        .o_l2_r_resp (r_resp), .o_l2_r_last (r_last),
        .o_l2_b_valid (b_valid), .i_l2_b_ready (b_ready), .o_l2_b_resp (b_resp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Beats moved for a size code: 16 bytes take two, a full line four
    function automatic int beats_for_size(input int size);
        int beats;
        if (size == 5) begin
            beats = 4;
        end else if (size == 4) begin
            beats = 2;
        end else begin
            beats = 1;
        end
        return beats;
    endfunction

    task automatic check_line(input string name, input l2_bus_pkg::line_t exp,
                              input l2_bus_pkg::line_t act, input int beats);
        l2_bus_pkg::line_t mask;
        mask = '1;
        mask = mask >> (l2_bus_pkg::LINE_W - beats * l2_bus_pkg::BUS_W);    // Defined lanes
        if ((exp & mask) !== (act & mask)) begin
            $display("CHECK FAILED %s: line expected %h actual %h", name, exp & mask, act & mask);
            test_errors++;
        end
    endtask

    task automatic check_resp(input string name, input l2_bus_pkg::resp_t exp,
                              input l2_bus_pkg::resp_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: resp expected %b actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: %s expected %b actual %b", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail with %0d errors", name, test_errors);
        end
    endtask

    task automatic load_golden(output bit ok);
        int                     fd, n, bp, size, resp;
        string                  text, name, op;
        logic [31:0]            addr;
        l2_bus_pkg::line_t      data, exp;
        l2_bus_pkg::line_strb_t strb;
        ok = 1'b1;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN);
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (n <= 1 || text.getc(0) == "#") begin
                continue;    // Blank or column notes
            end
            n = $sscanf(text, "%s %s %d %h %d %h %h %h %h",
                        name, op, bp, addr, size, data, strb, exp, resp);
            if (n != 9 || (op != "R" && op != "W")) begin
                $display("Malformed line in the golden file: %s", text);
                ok = 1'b0;
                continue;
            end
            t_name.push_back(name);
            t_op.push_back(op);
            t_bp.push_back(bp);
            t_addr.push_back(addr);
            t_size.push_back(size);
            t_data.push_back(data);
            t_strb.push_back(strb);
            t_exp.push_back(exp);
            t_resp.push_back(l2_bus_pkg::resp_t'(resp));
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int k);
        string             name;
        int                beats;
        l2_bus_pkg::line_t got;
        l2_bus_pkg::resp_t resp;
        name = t_name[k];
        beats = beats_for_size(t_size[k]);
        test_errors = 0;
        @(negedge clk);
        bp_mode = (t_bp[k] != 0);
        @(posedge clk);
        #1;
        r_pulses = 0;
        w_pulses = 0;
        if (t_op[k] == "R") begin
            ar_valid = 1'b1;
            ar_addr  = t_addr[k];
            ar_size  = l2_bus_pkg::size_t'(t_size[k]);
            @(negedge clk);
            while (ar_ready !== 1'b1) @(negedge clk);
            @(posedge clk);
            #1;
            ar_valid = 1'b0;
            @(negedge clk);
            while (r_valid !== 1'b1) @(negedge clk);    // Completion strobe
            got  = r_data;
            resp = r_resp;
            check_flag(name, "r_last", 1'b1, r_last);
            repeat (3) @(negedge clk);
            check_line(name, t_exp[k], got, beats);
            check_resp(name, t_resp[k], resp);
            check_count(name, "r_valid pulses", 1, r_pulses);
        end else begin
            aw_valid = 1'b1;
            aw_addr  = t_addr[k];
            aw_size  = l2_bus_pkg::size_t'(t_size[k]);
            w_data   = t_data[k];
            w_strb   = t_strb[k];
            @(negedge clk);
            while (aw_ready !== 1'b1) @(negedge clk);
            @(posedge clk);
            #1;
            aw_valid = 1'b0;
            @(negedge clk);
            while (!(b_valid === 1'b1 && b_ready === 1'b1)) @(negedge clk);
            resp = b_resp;
            repeat (3) @(negedge clk);
            check_resp(name, t_resp[k], resp);
            check_count(name, "w_ready pulses", 1, w_pulses);
        end
        finish_test(name);
    endtask

    // Counts completion strobes, each lasts a single cycle
    always @(negedge clk) begin
        if (r_valid === 1'b1) r_pulses++;
        if (w_ready === 1'b1) w_pulses++;
    end

    // Completion readies, random only during back-pressure tests
    always @(posedge clk) begin
        #1;
        if (bp_mode) begin
            rng = xorshift32(rng);
            r_ready = (rng[1:0] != 2'b00);
            b_ready = (rng[3:2] != 2'b00);
        end else begin
            r_ready = 1'b1;
            b_ready = 1'b1;
        end
    end

    initial begin
        bit loaded;
        ar_valid = 1'b0;
        ar_addr  = '0;
        ar_size  = '0;
        aw_valid = 1'b0;
        aw_addr  = '0;
        aw_size  = '0;
        w_data   = '0;
        w_strb   = '0;
        r_ready  = 1'b1;
        b_ready  = 1'b1;
        load_golden(loaded);
        if (!loaded) begin
            n_fail++;
        end
        n_tests = t_name.size();

        // Completion outputs quiet through and right after reset
        test_errors = 0;
        repeat (RST_CYCLES + 2) begin
            @(negedge clk);
            check_flag("reset_idle", "r_valid", 1'b0, r_valid);
            check_flag("reset_idle", "w_ready", 1'b0, w_ready);
            check_flag("reset_idle", "b_valid", 1'b0, b_valid);
        end
        finish_test("reset_idle");

        for (int k = 0; k < n_tests; k++) begin
            run_test(k);
        end

        repeat (4) @(posedge clk);
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog, sized once the test table is known
    initial begin
        wait (n_tests > 0);
        #((n_tests * TEST_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in %0d cycles", n_tests * TEST_CYCLES + 20);
        $display("TB FAILED");
        $finish;
    end

endmodule
